//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mcore
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the run prints the pass message
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/mcore_core.sv
// top of the microcoded core
// fetch, decode, microcode and exec stages with both bus ports
`timescale 1ns/100ps

module mcore_core
  import mcore_pkg::*;
#(
  parameter logic [BUS_AW-2:0] RESET_PC = '0
) (
  input  logic              clk,
  input  logic              rst,
  // fetch bus
  output logic [BUS_AW-1:0] umif_adr_o,
  input  logic [BUS_DW-1:0] umif_dat_i,
  output logic              umif_stb_o,
  input  logic              umif_ack_i,
  // exec bus
  output logic [BUS_AW-1:0] umie_adr_o,
  input  logic [BUS_DW-1:0] umie_dat_i,
  output logic [BUS_DW-1:0] umie_dat_o,
  output logic              umie_we_o,
  output logic              umie_stb_o,
  input  logic              umie_ack_i,
  output logic              halt_o
);

  instr_t            instr;
  logic              fvalid;
  dec_t              dec;
  exe_t              exe;
  logic              stall;
  logic              redirect;
  logic [BUS_AW-2:0] target;

  mcore_fetch #(
    .RESET_PC (RESET_PC)
  ) fetch_inst (
    .clk        (clk),
    .rst        (rst),
    .stall_i    (stall),
    .redirect_i (redirect),
    .target_i   (target),
    .halt_i     (halt_o),
    .instr_o    (instr),
    .fvalid_o   (fvalid),
    .bus_adr_o  (umif_adr_o),
    .bus_dat_i  (umif_dat_i),
    .bus_stb_o  (umif_stb_o),
    .bus_ack_i  (umif_ack_i)
  );

  mcore_decode decode_inst (
    .clk      (clk),
    .rst      (rst),
    .stall_i  (stall),
    .flush_i  (redirect),
    .instr_i  (instr),
    .fvalid_i (fvalid),
    .dec_o    (dec)
  );

  mcore_micro_rom micro_rom_inst (
    .clk     (clk),
    .rst     (rst),
    .stall_i (stall),
    .flush_i (redirect),
    .dec_i   (dec),
    .exe_o   (exe)
  );

  mcore_exec exec_inst (
    .clk        (clk),
    .rst        (rst),
    .exe_i      (exe),
    .stall_o    (stall),
    .redirect_o (redirect),
    .target_o   (target),
    .halt_o     (halt_o),
    .bus_adr_o  (umie_adr_o),
    .bus_dat_i  (umie_dat_i),
    .bus_dat_o  (umie_dat_o),
    .bus_we_o   (umie_we_o),
    .bus_stb_o  (umie_stb_o),
    .bus_ack_i  (umie_ack_i)
  );

endmodule

//--- hdl/mcore_decode.sv
// opcode to micro address decode
// and registered operand fields toward the microcode store
`timescale 1ns/100ps

module mcore_decode
  import mcore_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   stall_i,
  input  logic   flush_i,
  input  instr_t instr_i,
  input  logic   fvalid_i,
  output dec_t   dec_o
);

  logic [3:0] uaddr;

  always_comb
  begin
    unique case (instr_i.opcode)
      OP_LDI:  uaddr = UA_LDI;
      OP_ADD:  uaddr = UA_ADD;
      OP_SUB:  uaddr = UA_SUB;
      OP_AND:  uaddr = UA_AND;
      OP_XOR:  uaddr = UA_XOR;
      OP_LD:   uaddr = UA_LD;
      OP_ST:   uaddr = UA_ST;
      OP_JNZ:  uaddr = UA_JNZ;
      OP_HLT:  uaddr = UA_HLT;
      default: uaddr = UA_NOP;
    endcase
  end

  // valid bit cleared on flush and held on stall
  always_ff @(posedge clk)
  begin
    if (rst)
      dec_o.valid <= 1'b0;
    else if (flush_i)
      dec_o.valid <= 1'b0;
    else if (!stall_i)
      dec_o.valid <= fvalid_i;
  end

  // operand fields
  always_ff @(posedge clk)
  begin
    if (!stall_i)
    begin
      dec_o.micro_addr <= uaddr;
      dec_o.dst        <= instr_i.dst;
      dec_o.src        <= instr_i.src;
      dec_o.imm        <= instr_i.imm;
    end
  end

endmodule

//--- hdl/mcore_exec.sv
// exec stage: register file, ALU, zero flag,
// exec bus master, branch redirect and halt
`timescale 1ns/100ps

module mcore_exec
  import mcore_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  exe_t              exe_i,
  output logic              stall_o,
  output logic              redirect_o,
  output logic [BUS_AW-2:0] target_o,
  output logic              halt_o,
  output logic [BUS_AW-1:0] bus_adr_o,
  input  logic [BUS_DW-1:0] bus_dat_i,
  output logic [BUS_DW-1:0] bus_dat_o,
  output logic              bus_we_o,
  output logic              bus_stb_o,
  input  logic              bus_ack_i
);

  logic [15:0] regs [4];
  logic        zf;
  logic        active;
  logic        mem_op;
  logic        reg_wr;
  logic [15:0] opa;
  logic [15:0] opb;
  logic [15:0] result;

  // nothing executes once halted
  assign active = exe_i.valid && !halt_o;
  assign mem_op = active && (exe_i.u.mem_rd || exe_i.u.mem_wr);

  assign opa = regs[exe_i.dst];
  assign opb = regs[exe_i.src];

  // word address from the raw 8-bit immediate
  assign bus_adr_o = {{(BUS_AW-9){1'b0}}, exe_i.imm[7:0], 1'b0};
  assign bus_dat_o = opb;
  assign bus_stb_o = mem_op;
  assign bus_we_o  = mem_op && exe_i.u.mem_wr;
  assign stall_o   = bus_stb_o && !bus_ack_i;

  assign redirect_o = active && exe_i.u.branch_nz && !zf;
  assign target_o   = {{(BUS_AW-9){1'b0}}, exe_i.imm[7:0]};

  // a load only writes back in its ack cycle
  assign reg_wr = active && exe_i.u.reg_we && (!exe_i.u.mem_rd || bus_ack_i);

  always_comb
  begin
    unique case (exe_i.u.alu_op)
      ALU_IMM: result = exe_i.imm;
      ALU_ADD: result = opa + opb;
      ALU_SUB: result = opa - opb;
      ALU_AND: result = opa & opb;
      ALU_XOR: result = opa ^ opb;
      ALU_MEM: result = bus_dat_i;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reg_wr)
      regs[exe_i.dst] <= result;
  end

  // zero flag follows every register write, loads included
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      zf     <= 1'b0;
      halt_o <= 1'b0;
    end
    else
    begin
      if (reg_wr)
        zf <= (result == 16'd0);
      if (active && exe_i.u.halt)
        halt_o <= 1'b1;
    end
  end

endmodule

//--- hdl/mcore_fetch.sv
// fetch stage: program counter, fetch bus master
// and the instruction register toward decode
`timescale 1ns/100ps

module mcore_fetch
  import mcore_pkg::*;
#(
  parameter logic [BUS_AW-2:0] RESET_PC = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall_i,
  input  logic              redirect_i,
  input  logic [BUS_AW-2:0] target_i,
  input  logic              halt_i,
  output instr_t            instr_o,
  output logic              fvalid_o,
  output logic [BUS_AW-1:0] bus_adr_o,
  input  logic [BUS_DW-1:0] bus_dat_i,
  output logic              bus_stb_o,
  input  logic              bus_ack_i
);

  logic [BUS_AW-2:0] pc;
  logic [BUS_AW-2:0] tgt_q;
  logic              kill_q;
  logic              stb_q;
  logic              done;

  assign done      = stb_q && bus_ack_i;
  assign bus_stb_o = stb_q;
  assign bus_adr_o = {pc, 1'b0};

  // payload register, taken only at a good ack
  always_ff @(posedge clk)
  begin
    if (done && !kill_q && !redirect_i)
      instr_o <= instr_t'(bus_dat_i);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc       <= RESET_PC;
      tgt_q    <= '0;
      kill_q   <= 1'b0;
      stb_q    <= 1'b0;
      fvalid_o <= 1'b0;
    end
    else
    begin
      // word consumed by decode or thrown away by a redirect
      if (redirect_i || !stall_i)
        fvalid_o <= 1'b0;

      if (done)
      begin
        stb_q  <= 1'b0;
        kill_q <= 1'b0;
        if (kill_q)
          pc <= tgt_q;
        else if (!redirect_i)
        begin
          fvalid_o <= 1'b1;
          pc       <= pc + 1'b1;
        end
      end

      // address must stay put while a fetch is open
      if (redirect_i)
      begin
        if (stb_q && !bus_ack_i)
        begin
          kill_q <= 1'b1;
          tgt_q  <= target_i;
        end
        else
          pc <= target_i;
      end
      else if (!stb_q && !halt_i && (!fvalid_o || !stall_i))
        stb_q <= 1'b1;
    end
  end

endmodule

//--- hdl/mcore_micro_rom.sv
// microcode control word table
// and the microcode to exec pipeline register
`timescale 1ns/100ps

module mcore_micro_rom
  import mcore_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic stall_i,
  input  logic flush_i,
  input  dec_t dec_i,
  output exe_t exe_o
);

  function automatic uword_t ucode(input logic [3:0] ua);
    uword_t w;
    w = '0;
    unique case (ua)
      UA_LDI: w.reg_we = 1'b1;
      UA_ADD:
      begin
        w.alu_op = ALU_ADD;
        w.reg_we = 1'b1;
      end
      UA_SUB:
      begin
        w.alu_op = ALU_SUB;
        w.reg_we = 1'b1;
      end
      UA_AND:
      begin
        w.alu_op = ALU_AND;
        w.reg_we = 1'b1;
      end
      UA_XOR:
      begin
        w.alu_op = ALU_XOR;
        w.reg_we = 1'b1;
      end
      // load writes the bus word back into dst
      UA_LD:
      begin
        w.alu_op = ALU_MEM;
        w.reg_we = 1'b1;
        w.mem_rd = 1'b1;
      end
      UA_ST:  w.mem_wr = 1'b1;
      UA_JNZ: w.branch_nz = 1'b1;
      UA_HLT: w.halt = 1'b1;
      default: w = '0;
    endcase
    return w;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      exe_o.valid <= 1'b0;
    else if (flush_i)
      exe_o.valid <= 1'b0;
    else if (!stall_i)
      exe_o.valid <= dec_i.valid;
  end

  // control word and operands
  always_ff @(posedge clk)
  begin
    if (!stall_i)
    begin
      exe_o.u   <= ucode(dec_i.micro_addr);
      exe_o.dst <= dec_i.dst;
      exe_o.src <= dec_i.src;
      exe_o.imm <= {{8{dec_i.imm[7]}}, dec_i.imm};
    end
  end

endmodule

//--- hdl/mcore_pkg.sv
// shared types and constants of the microcoded core
// instruction, decode and microcode words, opcode and micro addresses
package mcore_pkg;

  localparam int BUS_AW = 20;
  localparam int BUS_DW = 16;

  // opcode encoding, anything else is a no-operation
  localparam logic [3:0] OP_LDI = 4'h1;
  localparam logic [3:0] OP_ADD = 4'h2;
  localparam logic [3:0] OP_SUB = 4'h3;
  localparam logic [3:0] OP_AND = 4'h4;
  localparam logic [3:0] OP_XOR = 4'h5;
  localparam logic [3:0] OP_LD  = 4'h8;
  localparam logic [3:0] OP_ST  = 4'h9;
  localparam logic [3:0] OP_JNZ = 4'hc;
  localparam logic [3:0] OP_HLT = 4'hf;

  // dense micro addresses, entry 0 is the no-operation word
  localparam logic [3:0] UA_NOP = 4'd0;
  localparam logic [3:0] UA_LDI = 4'd1;
  localparam logic [3:0] UA_ADD = 4'd2;
  localparam logic [3:0] UA_SUB = 4'd3;
  localparam logic [3:0] UA_AND = 4'd4;
  localparam logic [3:0] UA_XOR = 4'd5;
  localparam logic [3:0] UA_LD  = 4'd6;
  localparam logic [3:0] UA_ST  = 4'd7;
  localparam logic [3:0] UA_JNZ = 4'd8;
  localparam logic [3:0] UA_HLT = 4'd9;

  typedef struct packed {
    logic [3:0] opcode;
    logic [1:0] dst;
    logic [1:0] src;
    logic [7:0] imm;
  } instr_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] micro_addr;
    logic [1:0] dst;
    logic [1:0] src;
    logic [7:0] imm;
  } dec_t;

  typedef enum logic [2:0] {
    ALU_IMM = 3'd0,
    ALU_ADD = 3'd1,
    ALU_SUB = 3'd2,
    ALU_AND = 3'd3,
    ALU_XOR = 3'd4,
    ALU_MEM = 3'd5
  } alu_op_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    reg_we;
    logic    mem_rd;
    logic    mem_wr;
    logic    branch_nz;
    logic    halt;
  } uword_t;

  // immediate already sign extended here
  typedef struct packed {
    logic        valid;
    uword_t      u;
    logic [1:0]  dst;
    logic [1:0]  src;
    logic [15:0] imm;
  } exe_t;

endpackage

//--- src.f
hdl/mcore_pkg.sv
hdl/mcore_fetch.sv
hdl/mcore_decode.sv
hdl/mcore_micro_rom.sv
hdl/mcore_exec.sv
hdl/mcore_core.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_mcore.sv

//--- testbench/mcore_patterns.txt
# P word_addr instr and D word_addr data, hex memory word addresses
# E test adr dat, test 1 alu_ops 2 load_store 3 jnz_loop, adr is the bus byte address
P 010 1025
P 011 14F3
P 012 9080
P 013 9181
P 014 187E
P 015 2800
P 016 9282
P 017 3900
P 018 9283
P 019 4400
P 01A 9184
P 01B 5200
P 01C 9085
P 01D 8CA0
P 01E 9386
# countdown loop from 3, branch target 021
P 01F 1003
P 020 1401
P 021 9090
P 022 3100
P 023 C021
P 024 9191
P 025 7FFF
P 026 F000
# store after halt must never appear
P 027 9387
D 0A0 BEEF
E 1 00100 0025
E 1 00102 FFF3
E 1 00104 00A3
E 1 00106 00B0
E 1 00108 0021
E 1 0010A 0095
E 2 0010C BEEF
E 3 00120 0003
E 3 00120 0002
E 3 00120 0001
E 3 00122 0001

//--- testbench/tb_checker.sv
// watches the exec bus and halt_o of the core,
// compares stores against the expected list, checks reset and halt rules
`timescale 1ns/100ps

module tb_checker
  import mcore_pkg::*;
#(
  parameter logic [BUS_AW-2:0] RESET_PC = '0,
  parameter int                MAX_EXP  = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [BUS_AW-1:0] if_adr_i,
  input  logic              if_stb_i,
  input  logic [BUS_AW-1:0] ie_adr_i,
  input  logic [BUS_DW-1:0] ie_dat_i,
  input  logic              ie_we_i,
  input  logic              ie_stb_i,
  input  logic              ie_ack_i,
  input  logic              halt_i,
  input  int                exp_test_i [MAX_EXP],
  input  logic [BUS_AW-1:0] exp_adr_i [MAX_EXP],
  input  logic [BUS_DW-1:0] exp_dat_i [MAX_EXP],
  input  int                exp_cnt_i,
  output int                err_cnt_o,
  output logic              done_o
);

  localparam int EXP_AW = $clog2(MAX_EXP);
  // cycles watched after halt for late strobes
  localparam int DRAIN = 20;
  // first fetch goes to the byte address of the reset word
  localparam logic [BUS_AW-1:0] FIRST_ADR = BUS_AW'(RESET_PC) * BUS_AW'(2);

  int   errors      = 0;
  int   idx         = 0;
  int   halt_cycles = 0;
  logic seen_fetch  = 1'b0;
  logic prev_halt   = 1'b0;
  logic prev_if_stb = 1'b0;
  logic prev_ie_stb = 1'b0;

  assign err_cnt_o = errors;
  assign done_o    = (halt_cycles >= DRAIN);

  function automatic string test_name(input int t);
    case (t)
      1:       return "alu_ops";
      2:       return "load_store";
      3:       return "jnz_loop";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_store();
    logic [EXP_AW-1:0] k;
    if (idx >= exp_cnt_i)
    begin
      $display("extra store of %h to address %h beyond the expected list",
               ie_dat_i, ie_adr_i);
      errors++;
    end
    else
    begin
      k = idx[EXP_AW-1:0];
      if (ie_adr_i !== exp_adr_i[k] || ie_dat_i !== exp_dat_i[k])
      begin
        $display("MISMATCH %s: expected adr %h dat %h, actual adr %h dat %h",
                 test_name(exp_test_i[k]), exp_adr_i[k], exp_dat_i[k],
                 ie_adr_i, ie_dat_i);
        errors++;
      end
    end
    idx++;
  endtask

  // bus values sampled mid-cycle
  always @(negedge clk)
  begin
    if (rst)
    begin
      if (if_stb_i || ie_stb_i || halt_i)
      begin
        $display("a bus strobe or halt_o is high while reset is asserted");
        errors++;
      end
    end
    else
    begin
      if (if_stb_i && !seen_fetch)
      begin
        seen_fetch = 1'b1;
        if (if_adr_i !== FIRST_ADR)
        begin
          $display("MISMATCH reset_pc: expected adr %h, actual adr %h",
                   FIRST_ADR, if_adr_i);
          errors++;
        end
      end

      // transfer completes at the next rising edge
      if (ie_stb_i && ie_we_i && ie_ack_i)
        check_store();

      if (prev_halt)
      begin
        if (!halt_i)
        begin
          $display("halt_o dropped without a reset");
          errors++;
        end
        if ((if_stb_i && !prev_if_stb) || (ie_stb_i && !prev_ie_stb))
        begin
          $display("a bus strobe rose after the core halted");
          errors++;
        end
      end
      else if (halt_i && idx != exp_cnt_i)
      begin
        $display("core halted after %0d of %0d expected stores", idx, exp_cnt_i);
        errors++;
      end

      if (halt_i && halt_cycles < DRAIN)
        halt_cycles++;
    end

    prev_halt   = halt_i;
    prev_if_stb = if_stb_i;
    prev_ie_stb = ie_stb_i;
  end

endmodule

//--- testbench/tb_clock_gen.sv
// clock and reset generator for the core testbench
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int HALF_PERIOD = 5,
  parameter int RST_CYCLES  = 16
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // reset released just after a rising edge
  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

//--- testbench/tb_mcore.sv
// testbench top: pattern loading, fetch and exec memory models
// with random ack latency, core instance and run timeout
`timescale 1ns/100ps

module tb_mcore
  import mcore_pkg::*;
();

  localparam logic [BUS_AW-2:0] RESET_PC  = 19'h10;
  localparam int                MEM_WORDS = 1024;
  localparam int                MAX_EXP   = 64;
  localparam int                EXP_AW    = $clog2(MAX_EXP);
  localparam int                PER_ITEM  = 200;
  localparam string             PATTERN_FILE = "testbench/mcore_patterns.txt";

  logic              clk;
  logic              rst;
  logic [BUS_AW-1:0] umif_adr;
  logic [BUS_DW-1:0] umif_dat;
  logic              umif_stb;
  logic              umif_ack;
  logic [BUS_AW-1:0] umie_adr;
  logic [BUS_DW-1:0] umie_rdat;
  logic [BUS_DW-1:0] umie_wdat;
  logic              umie_we;
  logic              umie_stb;
  logic              umie_ack;
  logic              halt;

  // program and data share one word array
  logic [15:0]       mem [MEM_WORDS];
  int                exp_test [MAX_EXP];
  logic [BUS_AW-1:0] exp_adr [MAX_EXP];
  logic [BUS_DW-1:0] exp_dat [MAX_EXP];
  int                n_prog    = 0;
  int                n_exp     = 0;
  int                tb_errors = 0;
  int                chk_errors;
  logic              chk_done;
  integer            seed      = 32'h36ac;

  tb_clock_gen #(
    .HALF_PERIOD (5),
    .RST_CYCLES  (16)
  ) clock_gen_inst (
    .clk_o (clk),
    .rst_o (rst)
  );

  mcore_core #(
    .RESET_PC (RESET_PC)
  ) mcore_core_inst (
    .clk        (clk),
    .rst        (rst),
    .umif_adr_o (umif_adr),
    .umif_dat_i (umif_dat),
    .umif_stb_o (umif_stb),
    .umif_ack_i (umif_ack),
    .umie_adr_o (umie_adr),
    .umie_dat_i (umie_rdat),
    .umie_dat_o (umie_wdat),
    .umie_we_o  (umie_we),
    .umie_stb_o (umie_stb),
    .umie_ack_i (umie_ack),
    .halt_o     (halt)
  );

  tb_checker #(
    .RESET_PC (RESET_PC),
    .MAX_EXP  (MAX_EXP)
  ) checker_inst (
    .clk        (clk),
    .rst        (rst),
    .if_adr_i   (umif_adr),
    .if_stb_i   (umif_stb),
    .ie_adr_i   (umie_adr),
    .ie_dat_i   (umie_wdat),
    .ie_we_i    (umie_we),
    .ie_stb_i   (umie_stb),
    .ie_ack_i   (umie_ack),
    .halt_i     (halt),
    .exp_test_i (exp_test),
    .exp_adr_i  (exp_adr),
    .exp_dat_i  (exp_dat),
    .exp_cnt_i  (n_exp),
    .err_cnt_o  (chk_errors),
    .done_o     (chk_done)
  );

  function automatic int ack_delay();
    return {$random(seed)} % 4;
  endfunction

  // no-op words that carry their own address
  task automatic fill_memory();
    int i;
    for (i = 0; i < MEM_WORDS; i++)
      mem[i[9:0]] = 16'(i);
  endtask

  task automatic load_patterns();
    int               fd;
    int               n;
    logic [7:0]       kind;
    logic [31:0]      f1;
    logic [31:0]      f2;
    logic [31:0]      f3;
    logic [8*128-1:0] rest;
    bit               more;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0)
    begin
      $display("cannot open the pattern file %s", PATTERN_FILE);
      tb_errors++;
      return;
    end
    more = 1'b1;
    while (more)
    begin
      n = $fscanf(fd, " %c", kind);
      if (n != 1)
        more = 1'b0;
      else if (kind == "#")
        n = $fgets(rest, fd);
      else if ((kind == "P" || kind == "D") && $fscanf(fd, "%h %h", f1, f2) == 2)
      begin
        mem[f1[9:0]] = f2[15:0];
        if (kind == "P")
          n_prog++;
      end
      else if (kind == "E" && n_exp < MAX_EXP && $fscanf(fd, "%h %h %h", f1, f2, f3) == 3)
      begin
        exp_test[n_exp[EXP_AW-1:0]] = f1;
        exp_adr[n_exp[EXP_AW-1:0]]  = f2[BUS_AW-1:0];
        exp_dat[n_exp[EXP_AW-1:0]]  = f3[BUS_DW-1:0];
        n_exp++;
      end
      else
      begin
        $display("malformed record of kind '%c' in the pattern file", kind);
        tb_errors++;
        more = 1'b0;
      end
    end
    $fclose(fd);
  endtask

  // fetch bus memory
  initial
  begin : fetch_mem
    int   wait_left;
    logic busy;
    umif_dat  = '0;
    umif_ack  = 1'b0;
    wait_left = 0;
    busy      = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      if (umif_ack)
        umif_ack = 1'b0;
      else if (umif_stb && !rst)
      begin
        if (!busy)
        begin
          busy      = 1'b1;
          wait_left = ack_delay();
        end
        if (wait_left == 0)
        begin
          umif_dat = mem[umif_adr[10:1]];
          umif_ack = 1'b1;
          busy     = 1'b0;
        end
        else
          wait_left--;
      end
      else
        busy = 1'b0;
    end
  end

  // exec bus memory
  initial
  begin : exec_mem
    int   wait_left;
    logic busy;
    umie_rdat = '0;
    umie_ack  = 1'b0;
    wait_left = 0;
    busy      = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      if (umie_ack)
        umie_ack = 1'b0;
      else if (umie_stb && !rst)
      begin
        if (!busy)
        begin
          busy      = 1'b1;
          wait_left = ack_delay();
        end
        if (wait_left == 0)
        begin
          if (umie_we)
            mem[umie_adr[10:1]] = umie_wdat;
          else
            umie_rdat = mem[umie_adr[10:1]];
          umie_ack = 1'b1;
          busy     = 1'b0;
        end
        else
          wait_left--;
      end
      else
        busy = 1'b0;
    end
  end

  initial
  begin : main
    int limit;
    int cycles;
    fill_memory();
    load_patterns();
    limit  = PER_ITEM * (n_prog + n_exp);
    cycles = 0;
    while (!chk_done && cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!chk_done)
    begin
      $display("timeout: the core did not halt within %0d cycles", limit);
      tb_errors++;
    end
    $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
